// File: project.f
+incdir+include
logic/vga_timing_pkg.sv
logic/scene_pkg.sv
logic/vga_timing.sv
logic/reg_bank.sv
logic/scene_background.sv
logic/score_overlay.sv
logic/pixel_output.sv
logic/vga_game_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

// File: testbench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "display_cfg.svh"

module tb_top;

    localparam int DAY_CYCLES = 1000000;
    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int H_SYNC_END = H_SYNC_START + `H_SYNC;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int V_SYNC_END = V_SYNC_START + `V_SYNC;
    localparam int FRAME_WAIT = 2 * H_TOTAL * V_TOTAL;
    // Sky pixels this close to the day length are not checked
    localparam int NIGHT_MARGIN = 8;

    logic                 clk;
    logic                 reset;
    scene_pkg::bus_data_t writedata;
    logic                 write;
    logic                 chipselect;
    scene_pkg::reg_addr_t address;
    scene_pkg::channel_t  vga_r;
    scene_pkg::channel_t  vga_g;
    scene_pkg::channel_t  vga_b;
    logic                 vga_clk;
    logic                 vga_hs;
    logic                 vga_vs;
    logic                 vga_blank_n;
    logic                 vga_sync_n;

    integer                seed = 57793;
    int                    error_count = 0;
    int                    check_count = 0;
    scene_pkg::score_cfg_t score_model;

    // Scan position recovered from the output syncs
    int   cycle;
    bit   col_known = 1'b0;
    bit   row_known = 1'b0;
    int   col = 0;
    int   row = 0;
    int   frame_num = 0;
    logic prev_hs = 1'b1;
    logic prev_vs = 1'b1;

    // Sync and blank measurements
    bit hs_fall_seen = 1'b0;
    bit vs_fall_seen = 1'b0;
    int hs_fall_cycle = 0;
    int vs_fall_cycle = 0;
    int hs_low_len = 0;
    int vs_low_len = 0;
    int blank_in_line = 0;
    int active_lines = 0;

    // Coverage of the interesting pixel classes
    int lines_measured = 0;
    int frames_measured = 0;
    int day_sky_checks = 0;
    int night_sky_checks = 0;
    int stroke_checks = 0;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    vga_game_top #(
        .DAY_CYCLES (DAY_CYCLES)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .writedata   (writedata),
        .write       (write),
        .chipselect  (chipselect),
        .address     (address),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

    function automatic logic [7:0] glyph_row(input logic [3:0] digit, input int line);
        logic [63:0] rows;
        case (digit)
            4'd0: rows = {8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00};
            4'd1: rows = {8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00};
            4'd2: rows = {8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00};
            4'd3: rows = {8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00};
            4'd4: rows = {8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00};
            4'd5: rows = {8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00};
            4'd6: rows = {8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00};
            4'd7: rows = {8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00};
            4'd8: rows = {8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00};
            4'd9: rows = {8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00};
            default: rows = '0;
        endcase
        return rows[63 - 8 * line -: 8];
    endfunction

    // True where a set font pixel of the score digit lands
    function automatic bit in_stroke(input int r, input int c, input scene_pkg::score_cfg_t score);
        int         dx;
        int         dy;
        logic [7:0] bits;
        dx = c - int'(score.x);
        dy = r - int'(score.y);
        if (dx < 0 || dx >= `FONT_SIZE || dy < 0 || dy >= `FONT_SIZE) begin
            return 1'b0;
        end
        bits = glyph_row(score.digit, dy);
        return bits[7 - dx];
    endfunction

    function automatic scene_pkg::rgb_t rgb(input int red, input int green, input int blue);
        scene_pkg::rgb_t c;
        c.r = red[7:0];
        c.g = green[7:0];
        c.b = blue[7:0];
        return c;
    endfunction

    // Expected pixel colour for one scan point
    function automatic scene_pkg::rgb_t expected_rgb(input int r, input int c, input bit night,
                                                     input scene_pkg::score_cfg_t score);
        if (r >= `V_ACTIVE || c >= `H_ACTIVE || in_stroke(r, c, score)) begin
            return '0;
        end
        if (r < `GROUND_LINE_ROW) begin
            if (night) begin
                return rgb(`NIGHT_SKY_R, `NIGHT_SKY_G, `NIGHT_SKY_B);
            end
            return rgb(`DAY_SKY_R, `DAY_SKY_G, `DAY_SKY_B);
        end
        if (r == `GROUND_LINE_ROW) begin
            return '0;
        end
        if (r <= `STRIPE_LAST_ROW) begin
            return rgb(`LIGHT_GROUND_R, `LIGHT_GROUND_G, `LIGHT_GROUND_B);
        end
        return rgb(`DARK_GROUND_R, `DARK_GROUND_G, `DARK_GROUND_B);
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        $display("CHECK FAILED at time %0t: %s expected 0x%0h, got 0x%0h",
                 $time, name, exp_val, act_val);
        error_count++;
    endtask

    task automatic fail_with_note(input string note);
        $display("ERROR at time %0t: %s", $time, note);
        error_count++;
    endtask

    task automatic finish_run(input bit timed_out);
        $display("checks: %0d, errors: %0d, timeout: %0d", check_count, error_count, timed_out);
        if (timed_out || error_count != 0) begin
            $display("tests failed");
        end else begin
            $display("all tests passed");
        end
        $finish;
    endtask

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // Tracks the scan point from the output syncs and compares every sample
    always @(negedge clk) begin : scan_checker
        scene_pkg::rgb_t actual;
        scene_pkg::rgb_t expected;
        logic            exp_active;
        logic            exp_hs;
        logic            exp_vs;
        logic            hs_rise;
        logic            hs_fall;
        logic            vs_rise;
        logic            vs_fall;
        int              night_state;

        actual = {vga_r, vga_g, vga_b};
        hs_rise = !prev_hs && vga_hs;
        hs_fall = prev_hs && !vga_hs;
        vs_rise = !prev_vs && vga_vs;
        vs_fall = prev_vs && !vga_vs;

        if (reset) begin
            if (vga_hs !== 1'b1 || vga_vs !== 1'b1) begin
                fail_with_note("syncs not high during reset");
            end
            if (vga_blank_n !== 1'b0 || actual !== '0) begin
                fail_with_note("blank or colour not cleared during reset");
            end
        end else begin
            if (col_known) begin
                col = col + 1;
                if (col == H_TOTAL) begin
                    col = 0;
                    if (row_known) begin
                        row = row + 1;
                        if (row == V_TOTAL) begin
                            row = 0;
                            frame_num = frame_num + 1;
                        end
                    end
                end
            end
            if (hs_rise) begin
                if (col_known && col != H_SYNC_END) begin
                    log_mismatch("tracked column at hsync end", H_SYNC_END, col);
                end
                if (hs_fall_seen && hs_low_len != `H_SYNC) begin
                    log_mismatch("vga_hs low cycles", `H_SYNC, hs_low_len);
                end
                col = H_SYNC_END;
                col_known = 1'b1;
                // The first hsync pulse after reset belongs to row 0
                if (!row_known) begin
                    row = 0;
                    row_known = 1'b1;
                    frame_num = 0;
                end
            end
            if (vs_rise) begin
                if (row_known && row != V_SYNC_END) begin
                    log_mismatch("tracked row at vsync end", V_SYNC_END, row);
                end
                if (vs_fall_seen && vs_low_len != `V_SYNC * H_TOTAL) begin
                    log_mismatch("vga_vs low cycles", `V_SYNC * H_TOTAL, vs_low_len);
                end
                row = V_SYNC_END;
            end

            if (hs_fall) begin
                if (hs_fall_seen) begin
                    if (cycle - hs_fall_cycle != H_TOTAL) begin
                        log_mismatch("line length", H_TOTAL, cycle - hs_fall_cycle);
                    end
                    if (blank_in_line != 0 && blank_in_line != `H_ACTIVE) begin
                        log_mismatch("vga_blank_n high cycles in line", `H_ACTIVE, blank_in_line);
                    end
                    if (blank_in_line == `H_ACTIVE) begin
                        active_lines++;
                    end
                    lines_measured++;
                end
                hs_fall_seen = 1'b1;
                hs_fall_cycle = cycle;
                blank_in_line = 0;
                hs_low_len = 0;
            end
            if (vs_fall) begin
                if (vs_fall_seen) begin
                    if (cycle - vs_fall_cycle != H_TOTAL * V_TOTAL) begin
                        log_mismatch("frame length", H_TOTAL * V_TOTAL, cycle - vs_fall_cycle);
                    end
                    if (active_lines != `V_ACTIVE) begin
                        log_mismatch("active lines per frame", `V_ACTIVE, active_lines);
                    end
                    frames_measured++;
                end
                vs_fall_seen = 1'b1;
                vs_fall_cycle = cycle;
                active_lines = 0;
                vs_low_len = 0;
            end
            if (!vga_hs) begin
                hs_low_len++;
            end
            if (!vga_vs) begin
                vs_low_len++;
            end
            if (vga_blank_n) begin
                blank_in_line++;
            end

            check_count++;
            if (!vga_blank_n && actual !== '0) begin
                log_mismatch("rgb while blanked", 0, actual);
            end
            if (vga_sync_n !== 1'b0) begin
                log_mismatch("vga_sync_n", 0, vga_sync_n);
            end

            if (col_known && row_known) begin
                exp_active = (col < `H_ACTIVE) && (row < `V_ACTIVE);
                exp_hs = !((col >= H_SYNC_START) && (col < H_SYNC_END));
                exp_vs = !((row >= V_SYNC_START) && (row < V_SYNC_END));
                if (vga_blank_n !== exp_active) begin
                    log_mismatch("vga_blank_n", exp_active, vga_blank_n);
                end
                if (vga_hs !== exp_hs) begin
                    log_mismatch("vga_hs", exp_hs, vga_hs);
                end
                if (vga_vs !== exp_vs) begin
                    log_mismatch("vga_vs", exp_vs, vga_vs);
                end
                if (vga_clk !== col[0]) begin
                    log_mismatch("vga_clk", col[0], vga_clk);
                end
                if (exp_active) begin
                    // 0 day, 1 night, 2 too close to the switch to call
                    if (cycle < DAY_CYCLES) begin
                        night_state = 0;
                    end else if (cycle > DAY_CYCLES + NIGHT_MARGIN) begin
                        night_state = 1;
                    end else begin
                        night_state = 2;
                    end
                    if (night_state != 2 || row >= `GROUND_LINE_ROW) begin
                        expected = expected_rgb(row, col, night_state == 1, score_model);
                        if (actual !== expected) begin
                            log_mismatch("rgb", expected, actual);
                        end
                        if (in_stroke(row, col, score_model)) begin
                            stroke_checks++;
                        end else if (row < `GROUND_LINE_ROW && night_state == 1) begin
                            night_sky_checks++;
                        end else if (row < `GROUND_LINE_ROW) begin
                            day_sky_checks++;
                        end
                    end
                end
            end
        end

        prev_hs = vga_hs;
        prev_vs = vga_vs;
    end

    task automatic drive_bus(input int addr, input logic [31:0] data, input logic cs,
                             input logic wr);
        chipselect = cs;
        write      = wr;
        address    = addr[8:0];
        writedata  = data;
        tick();
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
    endtask

    // Random digit and box position, upper data bits filled with noise
    task automatic write_score(input int digit_base, input int digit_span);
        int          digit;
        int          x;
        int          y;
        logic [31:0] noise;
        digit = digit_base + int'($unsigned($random(seed)) % digit_span);
        x = int'($unsigned($random(seed)) % (`H_ACTIVE - `FONT_SIZE + 1));
        y = int'($unsigned($random(seed)) % (`GROUND_LINE_ROW - 2 * `FONT_SIZE + 1));
        noise = $random(seed);
        drive_bus(`REG_SCORE, {noise[31:4], digit[3:0]}, 1'b1, 1'b1);
        noise = $random(seed);
        drive_bus(`REG_SCORE_X, {noise[31:11], x[10:0]}, 1'b1, 1'b1);
        noise = $random(seed);
        drive_bus(`REG_SCORE_Y, {noise[31:10], y[9:0]}, 1'b1, 1'b1);
        score_model.digit = digit[3:0];
        score_model.x = x[10:0];
        score_model.y = y[9:0];
        $display("score digit %0d written at (%0d, %0d)", digit, x, y);
    endtask

    task automatic await_reset_release;
        int waited;
        waited = 0;
        while (reset) begin
            if (waited >= 20) begin
                $display("reset was never released");
                finish_run(1'b1);
            end
            tick();
            waited++;
        end
    endtask

    // Early vertical blanking, before the vsync pulse
    task automatic wait_for_vblank(input int frame);
        int waited;
        waited = 0;
        while (!(row_known && frame_num == frame && row > `V_ACTIVE && row < V_SYNC_START)) begin
            if (waited >= FRAME_WAIT) begin
                $display("vertical blanking of frame %0d never arrived", frame);
                finish_run(1'b1);
            end
            tick();
            waited++;
        end
    endtask

    initial begin
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        score_model.digit = '0;
        score_model.x = `SCORE_X_RESET;
        score_model.y = `SCORE_Y_RESET;

        await_reset_release();

        // Frame 0 shows the reset score, then writes that must be dropped
        wait_for_vblank(0);
        drive_bus(`REG_SCORE, 32'h5, 1'b0, 1'b1);
        drive_bus(`REG_SCORE_X, 32'd600, 1'b1, 1'b0);
        drive_bus(3, 32'h9, 1'b1, 1'b1);
        drive_bus(9'h101, 32'h7, 1'b1, 1'b1);

        wait_for_vblank(1);
        write_score(0, 10);

        // Digits without a glyph give an empty box
        wait_for_vblank(2);
        write_score(10, 6);

        wait_for_vblank(3);

        if (frames_measured < 2) begin
            fail_with_note("fewer than two complete frames were measured");
        end
        if (lines_measured < V_TOTAL) begin
            fail_with_note("too few complete lines were measured");
        end
        if (day_sky_checks == 0) begin
            fail_with_note("no day sky pixel was checked");
        end
        if (night_sky_checks == 0) begin
            fail_with_note("no night sky pixel was checked");
        end
        if (stroke_checks == 0) begin
            fail_with_note("no score digit pixel was checked");
        end
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 100 MHz simulation clock, 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for two rising edges, released just after the second
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: logic/vga_game_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "display_cfg.svh"

module vga_game_top #(
    parameter scene_pkg::cycle_count_t DAY_CYCLES = `DAY_CYCLES_DEFAULT
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire scene_pkg::bus_data_t  writedata,
    input  wire logic                  write,
    input  wire logic                  chipselect,
    input  wire scene_pkg::reg_addr_t  address,
    output scene_pkg::channel_t        vga_r,
    output scene_pkg::channel_t        vga_g,
    output scene_pkg::channel_t        vga_b,
    output logic                       vga_clk,
    output logic                       vga_hs,
    output logic                       vga_vs,
    output logic                       vga_blank_n,
    output logic                       vga_sync_n
);

    scene_pkg::bus_write_t      bus;
    scene_pkg::score_cfg_t      score_cfg;
    vga_timing_pkg::scan_pos_t  scan;
    vga_timing_pkg::scan_pos_t  scan_d;
    scene_pkg::rgb_t            bg_color;
    logic                       hit;

    // Host write strobe
    assign bus.strobe  = chipselect && write;
    assign bus.address = address;
    assign bus.data    = writedata;

    reg_bank u_regs (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .score_cfg (score_cfg)
    );

    vga_timing u_timing (
        .clk     (clk),
        .reset   (reset),
        .scan    (scan),
        .vga_clk (vga_clk)
    );

    scene_background #(
        .DAY_CYCLES (DAY_CYCLES)
    ) u_background (
        .clk    (clk),
        .reset  (reset),
        .scan   (scan),
        .color  (bg_color),
        .scan_d (scan_d)
    );

    score_overlay u_score (
        .clk       (clk),
        .reset     (reset),
        .scan      (scan),
        .score_cfg (score_cfg),
        .hit       (hit)
    );

    pixel_output u_out (
        .clk         (clk),
        .reset       (reset),
        .color       (bg_color),
        .scan_d      (scan_d),
        .hit         (hit),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n)
    );

    // Composite sync unused
    assign vga_sync_n = 1'b0;

endmodule

`default_nettype wire

// File: logic/pixel_output.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_output (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire scene_pkg::rgb_t            color,
    input  wire vga_timing_pkg::scan_pos_t  scan_d,
    input  wire logic                       hit,
    output scene_pkg::channel_t             vga_r,
    output scene_pkg::channel_t             vga_g,
    output scene_pkg::channel_t             vga_b,
    output logic                            vga_hs,
    output logic                            vga_vs,
    output logic                            vga_blank_n
);

    scene_pkg::rgb_t pixel;

    // Digit strokes are black, and so is everything outside the active area
    always_comb begin
        if (!scan_d.active || hit) begin
            pixel = '0;
        end else begin
            pixel = color;
        end
    end

    // Colour and syncs leave on the same edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            vga_r       <= pixel.r;
            vga_g       <= pixel.g;
            vga_b       <= pixel.b;
            vga_hs      <= scan_d.hsync_n;
            vga_vs      <= scan_d.vsync_n;
            vga_blank_n <= scan_d.active;
        end
    end

endmodule

`default_nettype wire

// File: logic/score_overlay.sv
`timescale 1ns/1ps
`default_nettype none

`include "display_cfg.svh"

module score_overlay (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire vga_timing_pkg::scan_pos_t  scan,
    input  wire scene_pkg::score_cfg_t      score_cfg,
    output logic                            hit
);

    // One glyph per entry, top row in the high byte, leftmost pixel in bit 7
    localparam logic [63:0] FONT_ROM [0:15] = '{
        64'h3C666E7E76663C00,
        64'h183818181818_7E00,
        64'h3C66061C30667E00,
        64'h3C66061C06663C00,
        64'h0C1C2C4C7E0C0C00,
        64'h7E607C0606663C00,
        64'h3C66607C66663C00,
        64'h7E060C1830303000,
        64'h3C66663C66663C00,
        64'h3C66663E06663C00,
        64'h0,
        64'h0,
        64'h0,
        64'h0,
        64'h0,
        64'h0
    };

    vga_timing_pkg::hpos_t dh;
    vga_timing_pkg::vpos_t dv;
    logic                  in_box;
    logic [63:0]           glyph;
    logic [7:0]            font_row;
    logic                  pixel_on;

    // Offsets inside the box, only meaningful when in_box is set
    assign dh = scan.h - score_cfg.x;
    assign dv = scan.v - score_cfg.y;

    assign in_box = (scan.h >= score_cfg.x) && (dh < `FONT_SIZE) &&
                    (scan.v >= score_cfg.y) && (dv < `FONT_SIZE);

    assign glyph = FONT_ROM[score_cfg.digit];

    // Row dv sits at byte 7 - dv, column dh at bit 7 - dh
    assign font_row = glyph[{~dv[2:0], 3'b000} +: 8];
    assign pixel_on = font_row[~dh[2:0]];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit <= 1'b0;
        end else begin
            hit <= in_box && pixel_on;
        end
    end

endmodule

`default_nettype wire

// File: logic/scene_background.sv
`timescale 1ns/1ps
`default_nettype none

`include "display_cfg.svh"

module scene_background #(
    parameter scene_pkg::cycle_count_t DAY_CYCLES = `DAY_CYCLES_DEFAULT
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire vga_timing_pkg::scan_pos_t  scan,
    output scene_pkg::rgb_t                 color,
    output vga_timing_pkg::scan_pos_t       scan_d
);

    localparam scene_pkg::rgb_t DAY_SKY = '{
        r: scene_pkg::channel_t'(`DAY_SKY_R),
        g: scene_pkg::channel_t'(`DAY_SKY_G),
        b: scene_pkg::channel_t'(`DAY_SKY_B)
    };
    localparam scene_pkg::rgb_t NIGHT_SKY = '{
        r: scene_pkg::channel_t'(`NIGHT_SKY_R),
        g: scene_pkg::channel_t'(`NIGHT_SKY_G),
        b: scene_pkg::channel_t'(`NIGHT_SKY_B)
    };
    localparam scene_pkg::rgb_t LIGHT_GROUND = '{
        r: scene_pkg::channel_t'(`LIGHT_GROUND_R),
        g: scene_pkg::channel_t'(`LIGHT_GROUND_G),
        b: scene_pkg::channel_t'(`LIGHT_GROUND_B)
    };
    localparam scene_pkg::rgb_t DARK_GROUND = '{
        r: scene_pkg::channel_t'(`DARK_GROUND_R),
        g: scene_pkg::channel_t'(`DARK_GROUND_G),
        b: scene_pkg::channel_t'(`DARK_GROUND_B)
    };

    scene_pkg::cycle_count_t day_timer;
    logic                    night;
    scene_pkg::rgb_t         bg_next;

    // Night is one way, timer freezes once it fires
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            day_timer <= '0;
            night     <= 1'b0;
        end else if (!night) begin
            if (day_timer == DAY_CYCLES) begin
                night <= 1'b1;
            end else begin
                day_timer <= day_timer + 1'b1;
            end
        end
    end

    // Bands by row only
    always_comb begin
        if (scan.v < `GROUND_LINE_ROW) begin
            bg_next = night ? NIGHT_SKY : DAY_SKY;
        end else if (scan.v == `GROUND_LINE_ROW) begin
            bg_next = '0;
        end else if (scan.v <= `STRIPE_LAST_ROW) begin
            bg_next = LIGHT_GROUND;
        end else begin
            bg_next = DARK_GROUND;
        end
    end

    // Scan struct travels along so the output stage stays aligned
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            color          <= '0;
            scan_d.h       <= '0;
            scan_d.v       <= '0;
            scan_d.active  <= 1'b0;
            scan_d.hsync_n <= 1'b1;
            scan_d.vsync_n <= 1'b1;
        end else begin
            color  <= bg_next;
            scan_d <= scan;
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "display_cfg.svh"

module reg_bank (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire scene_pkg::bus_write_t   bus,
    output scene_pkg::score_cfg_t        score_cfg
);

    localparam scene_pkg::reg_addr_t ADDR_SCORE = `REG_SCORE;
    localparam scene_pkg::reg_addr_t ADDR_SCORE_X = `REG_SCORE_X;
    localparam scene_pkg::reg_addr_t ADDR_SCORE_Y = `REG_SCORE_Y;

    localparam vga_timing_pkg::hpos_t X_RESET = `SCORE_X_RESET;
    localparam vga_timing_pkg::vpos_t Y_RESET = `SCORE_Y_RESET;

    // Writes land in one cycle, the host has no wait state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score_cfg.digit <= '0;
            score_cfg.x     <= X_RESET;
            score_cfg.y     <= Y_RESET;
        end else if (bus.strobe) begin
            case (bus.address)
                ADDR_SCORE: begin
                    score_cfg.digit <= bus.data[3:0];
                end
                ADDR_SCORE_X: begin
                    score_cfg.x <= bus.data[10:0];
                end
                ADDR_SCORE_Y: begin
                    score_cfg.y <= bus.data[9:0];
                end
                default: begin
                    // Unmapped address, write dropped
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "display_cfg.svh"

module vga_timing (
    input  wire logic                  clk,
    input  wire logic                  reset,
    output vga_timing_pkg::scan_pos_t  scan,
    output logic                       vga_clk
);

    localparam vga_timing_pkg::hpos_t H_TOTAL =
        `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam vga_timing_pkg::hpos_t H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam vga_timing_pkg::hpos_t H_SYNC_END = `H_ACTIVE + `H_FRONT + `H_SYNC;

    localparam vga_timing_pkg::vpos_t V_TOTAL =
        `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam vga_timing_pkg::vpos_t V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam vga_timing_pkg::vpos_t V_SYNC_END = `V_ACTIVE + `V_FRONT + `V_SYNC;

    vga_timing_pkg::hpos_t h_next;
    vga_timing_pkg::vpos_t v_next;

    // Next scan point, wrapping at end of line and end of field
    always_comb begin
        h_next = scan.h + 1'b1;
        v_next = scan.v;
        if (scan.h == H_TOTAL - 1'b1) begin
            h_next = '0;
            if (scan.v == V_TOTAL - 1'b1) begin
                v_next = '0;
            end else begin
                v_next = scan.v + 1'b1;
            end
        end
    end

    // Flags are computed from the next point so they line up with the counters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan.h       <= '0;
            scan.v       <= '0;
            scan.active  <= 1'b1;
            scan.hsync_n <= 1'b1;
            scan.vsync_n <= 1'b1;
        end else begin
            scan.h       <= h_next;
            scan.v       <= v_next;
            scan.active  <= (h_next < `H_ACTIVE) && (v_next < `V_ACTIVE);
            scan.hsync_n <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
            scan.vsync_n <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
        end
    end

    // Half the pixel clock for the DAC
    assign vga_clk = scan.h[0];

endmodule

`default_nettype wire

// File: logic/scene_pkg.sv
`default_nettype none

package scene_pkg;

    typedef logic [7:0] channel_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    // Score value with a glyph only for 0 to 9
    typedef logic [3:0] digit_t;

    typedef logic [8:0] reg_addr_t;

    typedef logic [31:0] bus_data_t;

    // One host write where strobe is chipselect and write together
    typedef struct packed {
        logic      strobe;
        reg_addr_t address;
        bus_data_t data;
    } bus_write_t;

    // Score digit and its top left corner on screen
    typedef struct packed {
        digit_t                digit;
        vga_timing_pkg::hpos_t x;
        vga_timing_pkg::vpos_t y;
    } score_cfg_t;

    // Day timer wide enough for the default day length
    typedef logic [31:0] cycle_count_t;

endpackage

`default_nettype wire

// File: logic/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

    // Pixel column, 0 to 1599
    typedef logic [10:0] hpos_t;

    // Line number, 0 to 524
    typedef logic [9:0] vpos_t;

    // Everything a later stage needs to know about the current pixel
    typedef struct packed {
        hpos_t h;
        vpos_t v;
        logic  active;
        logic  hsync_n;
        logic  vsync_n;
    } scan_pos_t;

endpackage

`default_nettype wire

// File: include/display_cfg.svh
`ifndef DISPLAY_CFG_SVH
`define DISPLAY_CFG_SVH

// Horizontal timing in pixel clocks
`define H_ACTIVE 1280
`define H_FRONT 32
`define H_SYNC 192
`define H_BACK 96

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// Scene band rows
`define GROUND_LINE_ROW 280
`define STRIPE_LAST_ROW 300

// Palette
`define DAY_SKY_R 135
`define DAY_SKY_G 206
`define DAY_SKY_B 235
`define NIGHT_SKY_R 10
`define NIGHT_SKY_G 10
`define NIGHT_SKY_B 40
`define LIGHT_GROUND_R 139
`define LIGHT_GROUND_G 69
`define LIGHT_GROUND_B 19
`define DARK_GROUND_R 100
`define DARK_GROUND_G 40
`define DARK_GROUND_B 10

// Host register map
`define REG_SCORE 0
`define REG_SCORE_X 1
`define REG_SCORE_Y 2

// Score position after reset
`define SCORE_X_RESET 25
`define SCORE_Y_RESET 41

// Cycles of daylight before the sky turns dark
`define DAY_CYCLES_DEFAULT 1250000000

`define FONT_SIZE 8

`endif
